//--- flist.f
hdl/flash_burst_pkg.sv
hdl/rcr_sequencer.sv
hdl/burst_fsm.sv
hdl/read_addr_counter.sv
hdl/read_data_buffer.sv
hdl/flash_burst_reader.sv
sim/flash_model.sv
sim/flash_burst_reader_properties.sv
sim/flash_burst_reader_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=flash_burst_reader_sim

verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
	--top-module flash_burst_reader_tb --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	exit 0
fi
exit 1

//--- sim/flash_burst_reader_tb.sv
// Directed tests of the burst reader against a behavioral flash and an arbiter stub
// Stops at the first failed check; every wait has its own cycle limit
`timescale 1ns/1ps

module flash_burst_reader_tb;
	import flash_burst_pkg::*;

	localparam int          ACCESS_CLK_DIVISOR = 10;
	localparam int          LATENCY_COUNT      = 4;
	localparam int          WAIT_LIMIT         = 400;
	localparam flash_addr_t BURST_A            = 25'h0001230;
	localparam flash_addr_t BURST_B            = 25'h0ABFFFA;
	localparam flash_addr_t BURST_C            = 25'h0400100;
	localparam flash_addr_t BURST_D            = 25'h1555550;

	logic        clk;
	logic        nreset;
	logic        request;
	logic        start;
	flash_addr_t start_addr;
	flash_addr_t stop_addr;
	logic        done;
	flash_data_t rd_data;
	logic        rd_valid;
	logic        rd_ready;
	logic        bus_request;
	logic        bus_granted;
	flash_pins_t flash;
	flash_data_t flash_data_in;
	logic [31:0] lfsr;
	int          grant_delay;

	flash_burst_reader #(
		.ACCESS_CLK_DIVISOR (ACCESS_CLK_DIVISOR),
		.LATENCY_COUNT      (LATENCY_COUNT)
	) flash_burst_reader_i (.*);

	flash_model #(.LATENCY_COUNT(LATENCY_COUNT)) flash_model_i (
		.clk      (clk),
		.flash    (flash),
		.data_out (flash_data_in)
	);

	bind flash_burst_reader flash_burst_reader_properties flash_burst_reader_properties_i (
		.clk      (clk),
		.nreset   (nreset),
		.flash    (flash),
		.rd_data  (rd_data),
		.rd_valid (rd_valid),
		.rd_ready (rd_ready)
	);

	// ****************************************
	// Helpers
	// ****************************************
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic flash_data_t word_at(input flash_addr_t a);
		return a[15:0] ^ 16'h5A5A;
	endfunction

	function automatic flash_pins_t idle_pins();
		flash_pins_t p;
		p            = '0;
		p.nadv       = 1'b1;
		p.nreset     = 1'b1;
		p.data_highz = 1'b1;
		return p;
	endfunction

	task automatic end_with_failure(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what);
		end_with_failure($sformatf("** Error at %0t ns: %s", $time, what));
	endtask

	task automatic wait_for_valid(input string what);
		int n;
		n = 0;
		while (!rd_valid) begin
			if (n == WAIT_LIMIT)
				end_with_failure($sformatf("Timed out waiting for the %s", what));
			n++;
			@(negedge clk);
		end
	endtask

	task automatic load_burst(input flash_addr_t first, input flash_addr_t last);
		start      = 1'b1;
		start_addr = first;
		stop_addr  = last;
		@(negedge clk);
		start = 1'b0;
	endtask

	// New start mid-burst, then flush the word left in the output buffer
	task automatic restart_burst(input flash_addr_t first, input flash_addr_t last);
		rd_ready = 1'b0;
		load_burst(first, last);
		rd_ready = 1'b1;
		repeat (3) @(negedge clk);
		rd_ready = 1'b0;
		assert (!rd_valid) else report_mismatch("old word still valid after restart");
	endtask

	task automatic receive_words(input flash_addr_t first, input int stop_idx,
			input int n_take, input bit random_ready);
		int   count;
		int   idle;
		logic take;
		count = 0;
		idle  = 0;
		while (count < n_take) begin
			take = 1'b1;
			if (random_ready) begin
				lfsr = lfsr_step(lfsr);
				take = lfsr[0];
			end
			assert (done == (count > stop_idx || (rd_valid && count == stop_idx)))
				else report_mismatch($sformatf("done is %0b after %0d words", done, count));
			if (rd_valid) begin
				assert (rd_data == word_at(first + flash_addr_t'(count)))
					else report_mismatch($sformatf("word %0d is %h, expected %h", count,
						rd_data, word_at(first + flash_addr_t'(count))));
			end
			rd_ready = take;
			if (rd_valid && take) begin
				count++;
				idle = 0;
			end else if (idle == WAIT_LIMIT) begin
				end_with_failure("Timed out waiting for a read word");
			end else begin
				idle++;
			end
			@(negedge clk);
		end
		rd_ready = 1'b0;
	endtask

	task automatic check_config(input int pulses, input int base);
		flash_addr_t cfg_addr;
		cfg_addr = flash_addr_t'((LATENCY_COUNT << 11) | 'h0CF);
		assert (flash_model_i.deselect_count == pulses && flash_model_i.reset_count == pulses)
			else report_mismatch($sformatf("%0d select and %0d reset pulses, expected %0d",
				flash_model_i.deselect_count, flash_model_i.reset_count, pulses));
		assert (flash_model_i.write_count == base + 2)
			else report_mismatch($sformatf("%0d RCR writes", flash_model_i.write_count));
		assert (flash_model_i.write_addr[base] == cfg_addr &&
				flash_model_i.write_data[base] == 16'h0060)
			else report_mismatch("first RCR write has wrong address or data");
		assert (flash_model_i.write_addr[base + 1] == cfg_addr &&
				flash_model_i.write_data[base + 1] == 16'h0003)
			else report_mismatch("second RCR write has wrong address or data");
	endtask

	// ****************************************
	// Tests
	// ****************************************
	task automatic test_reset_values();
		assert (flash == idle_pins() && !rd_valid && !done && !bus_request)
			else report_mismatch($sformatf("pins %h not inactive after reset", flash));
	endtask

	task automatic test_config_sequence();
		request = 1'b1;
		@(negedge clk);
		assert (bus_request) else report_mismatch("bus_request did not follow request");
		load_burst(BURST_A, BURST_A + 25'd7);
		wait_for_valid("first word");
		check_config(1, 0);
	endtask

	task automatic test_request_drop();
		int n;
		request = 1'b0;
		n       = 0;
		while (bus_request) begin
			if (n == WAIT_LIMIT)
				end_with_failure("Timed out waiting for bus_request to fall");
			n++;
			@(negedge clk);
		end
		assert (flash == idle_pins())
			else report_mismatch($sformatf("pins %h after request dropped", flash));
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Arbiter stub grants a few cycles after the request
	initial begin
		bus_granted = 1'b0;
		grant_delay = 0;
		forever begin
			@(negedge clk);
			if (!bus_request) begin
				bus_granted = 1'b0;
				grant_delay = 0;
			end else if (grant_delay < 3) begin
				grant_delay++;
			end else begin
				bus_granted = 1'b1;
			end
		end
	end

	initial begin
		nreset     = 1'b0;
		request    = 1'b0;
		start      = 1'b0;
		start_addr = '0;
		stop_addr  = '0;
		rd_ready   = 1'b0;
		lfsr       = 32'ha036;
		repeat (4) @(negedge clk);
		nreset = 1'b1;
		test_reset_values();
		test_config_sequence();
		receive_words(BURST_A, 7, 8, 1'b0);
		// Random back-pressure across a 16-bit address wrap
		restart_burst(BURST_B, BURST_B + 25'd19);
		receive_words(BURST_B, 19, 22, 1'b1);
		restart_burst(BURST_C, BURST_C + 25'd100);
		receive_words(BURST_C, 100, 5, 1'b1);
		restart_burst(BURST_D, BURST_D + 25'd5);
		wait_for_valid("first word of the new burst");
		check_config(4, 6);
		receive_words(BURST_D, 5, 8, 1'b1);
		test_request_drop();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- sim/flash_burst_reader_properties.sv
// Flash pin protocol and output handshake rules
// All sampled on the rising clock
`timescale 1ns/1ps

module flash_burst_reader_properties (
	input logic                         clk,
	input logic                         nreset,
	input flash_burst_pkg::flash_pins_t flash,
	input flash_burst_pkg::flash_data_t rd_data,
	input logic                         rd_valid,
	input logic                         rd_ready
);

	write_not_with_read: assert property (@(posedge clk) disable iff (!nreset)
		!(flash.write && flash.read))
		else $error("flash write and read enable high together");

	write_needs_select: assert property (@(posedge clk) disable iff (!nreset)
		flash.write |-> flash.select)
		else $error("flash write without chip select");

	clk_low_in_write: assert property (@(posedge clk) disable iff (!nreset)
		!(flash.clk && flash.write))
		else $error("flash clock high during a write");

	// Stalled word must stay put
	data_held: assert property (@(posedge clk) disable iff (!nreset)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_data))
		else $error("rd_data or rd_valid changed while stalled");

endmodule

//--- sim/flash_model.sv
// Behavioral burst flash; pin edges are seen one system clock after they happen
// Data word for an address is its low 16 bits XOR 16'h5A5A
`timescale 1ns/1ps

module flash_model #(
	parameter int LATENCY_COUNT = 4
) (
	input  logic                         clk,
	input  flash_burst_pkg::flash_pins_t flash,
	output flash_burst_pkg::flash_data_t data_out
);
	import flash_burst_pkg::*;

	localparam int LOG_DEPTH = 16;

	logic        prev_clk    = 1'b0;
	logic        prev_select = 1'b0;
	logic        prev_nreset = 1'b1;
	logic        prev_write  = 1'b0;
	logic        burst_on    = 1'b0;
	int          edge_count  = 0;
	int          deselect_count = 0;
	int          reset_count = 0;
	int          write_count = 0;
	flash_addr_t next_addr   = '0;
	flash_data_t word_q      = '0;
	flash_addr_t write_addr [LOG_DEPTH];
	flash_data_t write_data [LOG_DEPTH];

	assign data_out = word_q;

	always @(posedge clk) begin
		prev_clk    <= flash.clk;
		prev_select <= flash.select;
		prev_nreset <= flash.nreset;
		prev_write  <= flash.write;
		if (!flash.select && prev_select)
			deselect_count <= deselect_count + 1;
		if (!flash.nreset && prev_nreset)
			reset_count <= reset_count + 1;
		// Log each configuration write once
		if (flash.write && !prev_write) begin
			if (write_count < LOG_DEPTH) begin
				write_addr[write_count] <= flash.addr;
				write_data[write_count] <= flash.wdata;
			end
			write_count <= write_count + 1;
		end
		if (!flash.nreset) begin
			burst_on <= 1'b0;
		end else if (flash.clk && !prev_clk) begin
			if (!flash.nadv) begin
				next_addr  <= flash.addr;
				edge_count <= 0;
				burst_on   <= 1'b1;
			end else if (burst_on) begin
				// Last latency edge and every later edge present a new word
				if (edge_count + 1 >= LATENCY_COUNT) begin
					word_q    <= next_addr[15:0] ^ 16'h5A5A;
					next_addr <= next_addr + 1'b1;
				end
				edge_count <= edge_count + 1;
			end
		end
	end

endmodule

//--- hdl/flash_burst_reader.sv
// Burst reader top; the controller holds request for the whole session
// Pins follow flash_pins_t, flash_data_in is sampled in READ_LOW
`timescale 1ns/1ps

module flash_burst_reader #(
	parameter int ACCESS_CLK_DIVISOR = 10,
	parameter int LATENCY_COUNT      = 4
) (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         request,
	input  logic                         start,
	input  flash_burst_pkg::flash_addr_t start_addr,
	input  flash_burst_pkg::flash_addr_t stop_addr,
	output logic                         done,
	output flash_burst_pkg::flash_data_t rd_data,
	output logic                         rd_valid,
	input  logic                         rd_ready,
	output logic                         bus_request,
	input  logic                         bus_granted,
	output flash_burst_pkg::flash_pins_t flash,
	input  flash_burst_pkg::flash_data_t flash_data_in
);
	import flash_burst_pkg::*;

	logic        cfg_start;
	logic        cfg_done;
	flash_addr_t cfg_addr;
	flash_data_t cfg_wdata;
	logic        cfg_write;
	logic        in_valid;
	logic        in_accept;
	flash_addr_t cur_addr;
	logic        addr_loaded;
	logic        lat_entered;

	burst_fsm #(
		.ACCESS_CLK_DIVISOR (ACCESS_CLK_DIVISOR),
		.LATENCY_COUNT      (LATENCY_COUNT)
	) burst_fsm_i (
		.clk         (clk),
		.nreset      (nreset),
		.request     (request),
		.bus_granted (bus_granted),
		.bus_request (bus_request),
		.addr_loaded (addr_loaded),
		.cur_addr    (cur_addr),
		.lat_entered (lat_entered),
		.cfg_start   (cfg_start),
		.cfg_done    (cfg_done),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_write   (cfg_write),
		.in_valid    (in_valid),
		.in_accept   (in_accept),
		.flash       (flash)
	);

	rcr_sequencer #(
		.ACCESS_CLK_DIVISOR (ACCESS_CLK_DIVISOR),
		.LATENCY_COUNT      (LATENCY_COUNT)
	) rcr_sequencer_i (
		.clk       (clk),
		.nreset    (nreset),
		.cfg_start (cfg_start),
		.cfg_done  (cfg_done),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_write (cfg_write)
	);

	read_addr_counter read_addr_counter_i (
		.clk         (clk),
		.nreset      (nreset),
		.start       (start),
		.start_addr  (start_addr),
		.stop_addr   (stop_addr),
		.in_accept   (in_accept),
		.lat_entered (lat_entered),
		.cur_addr    (cur_addr),
		.addr_loaded (addr_loaded),
		.done        (done)
	);

	// in_ready is already folded into in_accept
	read_data_buffer read_data_buffer_i (
		.clk       (clk),
		.nreset    (nreset),
		.in_valid  (in_valid),
		.in_data   (flash_data_in),
		.in_ready  (),
		.in_accept (in_accept),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid),
		.rd_ready  (rd_ready)
	);

endmodule

//--- hdl/read_data_buffer.sv
// Single entry, so throughput is one word per cycle only if rd_ready stays high
`timescale 1ns/1ps

module read_data_buffer (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         in_valid,
	input  flash_burst_pkg::flash_data_t in_data,
	output logic                         in_ready,
	output logic                         in_accept,
	output flash_burst_pkg::flash_data_t rd_data,
	output logic                         rd_valid,
	input  logic                         rd_ready
);
	import flash_burst_pkg::*;

	logic        full;
	flash_data_t data_q;

	// Room when empty or when the held word leaves this cycle
	assign in_ready  = !full || rd_ready;
	assign in_accept = in_valid && in_ready;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			full <= 1'b0;
		else if (in_accept)
			full <= 1'b1;
		else if (rd_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_accept)
			data_q <= in_data;
	end

	assign rd_valid = full;
	assign rd_data  = data_q;

endmodule

//--- hdl/read_addr_counter.sv
// Start has priority over a word accepted in the same cycle
`timescale 1ns/1ps

module read_addr_counter (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         start,
	input  flash_burst_pkg::flash_addr_t start_addr,
	input  flash_burst_pkg::flash_addr_t stop_addr,
	input  logic                         in_accept,
	input  logic                         lat_entered,
	output flash_burst_pkg::flash_addr_t cur_addr,
	output logic                         addr_loaded,
	output logic                         done
);
	import flash_burst_pkg::*;

	logic        advance;
	flash_addr_t stop_q;

	// Words taken before the FSM has picked up a new load are ignored
	assign advance = in_accept && !addr_loaded && !start;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			addr_loaded <= 1'b0;
			done        <= 1'b0;
		end else if (start) begin
			addr_loaded <= 1'b1;
			done        <= 1'b0;
		end else begin
			if (lat_entered)
				addr_loaded <= 1'b0;
			if (advance && cur_addr == stop_q)
				done <= 1'b1;
		end
	end

	// Address payload
	always_ff @(posedge clk) begin
		if (start) begin
			cur_addr <= start_addr;
			stop_q   <= stop_addr;
		end else if (advance) begin
			cur_addr <= cur_addr + 1'b1;
		end
	end

endmodule

//--- hdl/burst_fsm.sv
// Owns the flash pins; all pin fields decode from the registered state
// A new address load is only acted on in the read states
`timescale 1ns/1ps

module burst_fsm #(
	parameter int ACCESS_CLK_DIVISOR = 10,
	parameter int LATENCY_COUNT      = 4
) (
	input  logic                         clk,
	input  logic                         nreset,
	input  logic                         request,
	input  logic                         bus_granted,
	output logic                         bus_request,
	input  logic                         addr_loaded,
	input  flash_burst_pkg::flash_addr_t cur_addr,
	output logic                         lat_entered,
	output logic                         cfg_start,
	input  logic                         cfg_done,
	input  flash_burst_pkg::flash_addr_t cfg_addr,
	input  flash_burst_pkg::flash_data_t cfg_wdata,
	input  logic                         cfg_write,
	output logic                         in_valid,
	input  logic                         in_accept,
	output flash_burst_pkg::flash_pins_t flash
);
	import flash_burst_pkg::*;

	localparam int LAT_CLAMPED = (LATENCY_COUNT < 3) ? 3 :
		(LATENCY_COUNT > 7) ? 7 : LATENCY_COUNT;
	localparam word_idx_t   LAT_LAST    = word_idx_t'(LAT_CLAMPED - 1);
	localparam word_idx_t   RESET_LAST  = word_idx_t'(RESET_PERIODS - 1);
	localparam period_cnt_t PERIOD_LAST = period_cnt_t'(ACCESS_CLK_DIVISOR);

	burst_state_t state;
	burst_state_t state_next;
	logic         granted;
	period_cnt_t  acc_cnt;
	word_idx_t    idx;
	logic         counting;
	logic         period_end;
	logic         reset_step_last;

	// ****************************************
	// Bus arbitration
	// ****************************************
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			bus_request <= 1'b0;
			granted     <= 1'b0;
		end else begin
			bus_request <= request;
			if (!request)
				granted <= 1'b0;
			else if (!granted)
				granted <= bus_granted;
		end
	end

	// ****************************************
	// Access period and step counters
	// ****************************************
	assign counting        = state inside {DESELECT, RESET_PULSE, DUMMY};
	assign period_end      = counting && (acc_cnt == PERIOD_LAST);
	assign reset_step_last = period_end && (idx == RESET_LAST);

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			acc_cnt <= '0;
		else if (!counting || period_end || state_next != state)
			acc_cnt <= '0;
		else
			acc_cnt <= acc_cnt + 1'b1;
	end

	// Counts reset periods, or latency pairs
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			idx <= '0;
		else if ((state_next != state && state_next inside {DESELECT, RESET_PULSE}) ||
				state == ADDR_HIGH)
			idx <= '0;
		else if ((state inside {DESELECT, RESET_PULSE} && period_end) || state == LAT_HIGH)
			idx <= idx + 1'b1;
	end

	// ****************************************
	// State machine
	// ****************************************
	always_comb begin
		state_next = state;
		if (!request || !granted) begin
			state_next = WAIT;
		end else begin
			case (state)
				WAIT:        if (addr_loaded) state_next = DESELECT;
				DESELECT:    if (reset_step_last) state_next = RESET_PULSE;
				RESET_PULSE: if (reset_step_last) state_next = CONFIGURE;
				CONFIGURE:   if (cfg_done) state_next = DUMMY;
				DUMMY:       if (period_end) state_next = ADDR_LOW;
				ADDR_LOW:    state_next = ADDR_HIGH;
				ADDR_HIGH:   state_next = LAT_LOW;
				LAT_LOW:     state_next = LAT_HIGH;
				LAT_HIGH:    state_next = (idx == LAT_LAST) ? READ_LOW : LAT_LOW;
				READ_LOW: begin
					// Stall here with clk low under back-pressure
					if (addr_loaded)
						state_next = DESELECT;
					else if (in_accept)
						state_next = READ_HIGH;
				end
				READ_HIGH:   state_next = addr_loaded ? DESELECT : READ_LOW;
				default:     state_next = WAIT;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset)
			state <= WAIT;
		else
			state <= state_next;
	end

	assign cfg_start   = (state_next == CONFIGURE) && (state != CONFIGURE);
	assign lat_entered = (state == ADDR_HIGH) && (state_next == LAT_LOW);
	assign in_valid    = (state == READ_LOW) && !addr_loaded;

	// Pin decode
	always_comb begin
		flash.select     = granted && !(state == DESELECT && idx == '0);
		flash.read       = state inside {LAT_LOW, LAT_HIGH, READ_LOW, READ_HIGH};
		flash.write      = (state == CONFIGURE) && cfg_write;
		flash.clk        = state inside {ADDR_HIGH, LAT_HIGH, READ_HIGH};
		flash.nadv       = !(state inside {CONFIGURE, ADDR_LOW, ADDR_HIGH});
		flash.nreset     = !(state == RESET_PULSE && idx == '0);
		flash.data_highz = (state != CONFIGURE);
		flash.wdata      = (state == CONFIGURE) ? cfg_wdata : '0;
		case (state)
			CONFIGURE:                             flash.addr = cfg_addr;
			ADDR_LOW, ADDR_HIGH, LAT_LOW, LAT_HIGH: flash.addr = cur_addr;
			default:                               flash.addr = '0;
		endcase
	end

endmodule

//--- hdl/rcr_sequencer.sv
// Writes the two-word RCR sequence, three access periods per word
// LATENCY_COUNT is clamped to 3..7 before it is encoded
`timescale 1ns/1ps

module rcr_sequencer #(
	parameter int ACCESS_CLK_DIVISOR = 10,
	parameter int LATENCY_COUNT      = 4
) (
	input  logic                       clk,
	input  logic                       nreset,
	input  logic                       cfg_start,
	output logic                       cfg_done,
	output flash_burst_pkg::flash_addr_t cfg_addr,
	output flash_burst_pkg::flash_data_t cfg_wdata,
	output logic                       cfg_write
);
	import flash_burst_pkg::*;

	typedef enum logic [1:0] {PH_IDLE, PH_ADDR, PH_WRITE, PH_HOLD} phase_t;

	localparam int LAT_CLAMPED = (LATENCY_COUNT < 3) ? 3 :
		(LATENCY_COUNT > 7) ? 7 : LATENCY_COUNT;
	localparam logic [2:0]  LAT_CODE    = 3'(LAT_CLAMPED);
	localparam period_cnt_t PERIOD_LAST = period_cnt_t'(ACCESS_CLK_DIVISOR);
	localparam flash_addr_t CFG_ADDR    = {{(ADDR_W - 14){1'b0}}, LAT_CODE, RCR_CODE_BASE};

	phase_t      phase;
	period_cnt_t cnt;
	word_idx_t   word;
	logic        period_end;
	flash_data_t word_data;

	// Command table
	always_comb begin
		case (word)
			word_idx_t'(0): word_data = RCR_CMD_SETUP;
			default:        word_data = RCR_CMD_CONFIRM;
		endcase
	end

	assign period_end = (phase != PH_IDLE) && (cnt == PERIOD_LAST);

	// Address, write and hold phase of each word
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			phase    <= PH_IDLE;
			cnt      <= '0;
			word     <= '0;
			cfg_done <= 1'b0;
		end else begin
			cfg_done <= 1'b0;
			if (cfg_start) begin
				phase <= PH_ADDR;
				cnt   <= '0;
				word  <= '0;
			end else if (period_end) begin
				cnt <= '0;
				case (phase)
					PH_ADDR:  phase <= PH_WRITE;
					PH_WRITE: phase <= PH_HOLD;
					default: begin
						if (word == word_idx_t'(RCR_WORDS - 1)) begin
							phase    <= PH_IDLE;
							cfg_done <= 1'b1;
						end else begin
							word  <= word + 1'b1;
							phase <= PH_ADDR;
						end
					end
				endcase
			end else if (phase != PH_IDLE) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign cfg_write = (phase == PH_WRITE);
	assign cfg_addr  = (phase != PH_IDLE) ? CFG_ADDR : '0;
	assign cfg_wdata = (phase != PH_IDLE) ? word_data : '0;

endmodule

//--- hdl/flash_burst_pkg.sv
// Widths are fixed here because the pin struct is packed
// Only the Intel StrataFlash RCR command set is supported
package flash_burst_pkg;

	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;

	typedef logic [ADDR_W-1:0] flash_addr_t;
	typedef logic [DATA_W-1:0] flash_data_t;
	typedef logic [3:0]        period_cnt_t;
	typedef logic [2:0]        word_idx_t;

	typedef enum logic [3:0] {
		WAIT,
		DESELECT,
		RESET_PULSE,
		CONFIGURE,
		DUMMY,
		ADDR_LOW,
		ADDR_HIGH,
		LAT_LOW,
		LAT_HIGH,
		READ_LOW,
		READ_HIGH
	} burst_state_t;

	// Outputs towards the flash device
	typedef struct packed {
		logic        select;
		logic        read;
		logic        write;
		logic        clk;
		logic        nadv;
		logic        nreset;
		logic        data_highz;
		flash_addr_t addr;
		flash_data_t wdata;
	} flash_pins_t;

	// RCR write sequence
	// Latency goes in address bits 13..11
	localparam flash_data_t RCR_CMD_SETUP   = 16'h0060;
	localparam flash_data_t RCR_CMD_CONFIRM = 16'h0003;
	localparam logic [10:0] RCR_CODE_BASE   = 11'h0CF;
	localparam int          RCR_WORDS       = 2;
	localparam int          RESET_PERIODS   = 4;

endpackage
